//--- flist.f
+incdir+include
logic/fft_load_pkg.sv
logic/uart_rx.sv
logic/sample_pack.sv
logic/frame_loader.sv
logic/fft_load_top.sv
sim/fft_load_sva.sv
sim/fft_load_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the FFT load testbench with Verilator, then scan the log for failure

verilator --binary --timing --timescale 1ns/100ps -f flist.f \
   --top-module fft_load_tb -o fft_load_sim > build.log 2>&1 &&
./obj_dir/fft_load_sim > sim.log 2>&1 ||
{ echo "Build or simulation did not complete, see build.log and sim.log"; exit 1; }

cat sim.log

! grep -q "Simulation finished: FAIL" sim.log ||
{ echo "Run failed, see sim.log"; exit 1; }

echo "Run passed"
exit 0

//--- sim/fft_load_tb.sv
// Testbench for fft_load_top that drives serial bytes, models the expected beats and checks them
`include "fft_load_defs.svh"

module fft_load_tb;

   timeunit 1ns;
   timeprecision 100ps;

   localparam logic [31:0] SEED = 32'h97a0_9d84;
   // About 108 bytes of 160 cycles each
   // Rounded up for error bytes, resets and drain
   localparam int TIMEOUT_CYCLES = 20000;
   // Last beat leaves the loader a few cycles after its stop bit
   localparam int DRAIN_CYCLES = 2 * `UART_BIT_TICKS;

   logic                      clk;
   logic                      rst_n;
   logic                      rx_i;
   fft_load_pkg::frame_beat_t beat_o;
   logic                      valid_o;
   logic                      frame_done_o;
   logic                      rx_err_o;

   // Expected beats and their frame end flags in send order
   fft_load_pkg::frame_beat_t exp_q[$];
   logic                      last_q[$];

   int                   model_cnt;
   int                   val_errs;
   int                   misc_errs;
   int                   rx_err_exp;
   int                   rx_err_seen;
   int                   frames_seen;
   int                   cycle_cnt;
   logic                 done_exp;
   logic [`FFT_POINTS-1:0] seen_mask;

   fft_load_top UUT (
      .clk          (clk),
      .rst_n        (rst_n),
      .rx_i         (rx_i),
      .beat_o       (beat_o),
      .valid_o      (valid_o),
      .frame_done_o (frame_done_o),
      .rx_err_o     (rx_err_o)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // -------------------------------------------------------------------------
   // Reference model
   // -------------------------------------------------------------------------

   // Expected beat from the two sent bytes and the model sample index
   function automatic fft_load_pkg::frame_beat_t ref_beat(input logic [7:0] re_b,
                                                          input logic [7:0] im_b,
                                                          input int idx);
      fft_load_pkg::frame_beat_t bt;
      int re_v;
      int im_v;
      int rev;
      re_v = int'($signed(re_b)) * 256;
      im_v = int'($signed(im_b)) * 256;
      rev  = 0;
      // Low index bit ends up as the high address bit
      for (int i = 0; i < `FFT_LOG2; i++) begin
         rev = rev * 2 + ((idx >> i) & 1);
      end
      bt.sample.re = `SAMPLE_W'(re_v);
      bt.sample.im = `SAMPLE_W'(im_v);
      bt.addr      = `FFT_LOG2'(rev);
      return bt;
   endfunction

   function automatic logic [7:0] random_byte();
      return 8'($urandom());
   endfunction

   // -------------------------------------------------------------------------
   // Serial driver
   // -------------------------------------------------------------------------

   // 8N1 frame LSB first with a selectable stop bit level
   task automatic send_byte(input logic [7:0] b, input logic stop_bit);
      logic [9:0] bits;
      bits = {stop_bit, b, 1'b0};
      for (int i = 0; i < 10; i++) begin
         @(posedge clk);
         rx_i <= bits[i];
         repeat (`UART_BIT_TICKS - 1) @(posedge clk);
      end
      // Line back to idle so the next start edge is seen
      if (!stop_bit) begin
         @(posedge clk);
         rx_i <= 1'b1;
         repeat (`UART_BIT_TICKS - 1) @(posedge clk);
      end
   endtask

   // One complex sample with an optional broken byte between the halves
   task automatic send_pair(input logic [7:0] re_b, input logic [7:0] im_b,
                            input logic bad_mid);
      exp_q.push_back(ref_beat(re_b, im_b, model_cnt));
      last_q.push_back(model_cnt == `FFT_POINTS - 1);
      model_cnt = (model_cnt + 1) % `FFT_POINTS;
      send_byte(re_b, 1'b1);
      if (bad_mid) begin
         rx_err_exp++;
         send_byte(random_byte(), 1'b0);
      end
      send_byte(im_b, 1'b1);
   endtask

   task automatic send_random_pairs(input int n, input int bad_at);
      logic [7:0] re_b;
      logic [7:0] im_b;
      for (int i = 0; i < n; i++) begin
         re_b = random_byte();
         im_b = random_byte();
         send_pair(re_b, im_b, i == bad_at);
      end
   endtask

   // Wait for outstanding beats plus room for the frame end pulse
   task automatic drain_beats();
      int waited;
      waited = 0;
      while (exp_q.size() != 0 && waited < DRAIN_CYCLES) begin
         @(posedge clk);
         waited++;
      end
      if (exp_q.size() != 0) begin
         $display("%0d expected beats never appeared", exp_q.size());
         misc_errs++;
         exp_q.delete();
         last_q.delete();
      end
      repeat (4) @(posedge clk);
   endtask

   task automatic pulse_reset();
      @(posedge clk);
      rst_n <= 1'b0;
      repeat (10) @(posedge clk);
      rst_n <= 1'b1;
   endtask

   task automatic finish_run();
      $display("Errors: value mismatches %0d, other failures %0d", val_errs, misc_errs);
      if (val_errs == 0 && misc_errs == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   endtask

   // -------------------------------------------------------------------------
   // Compare process sampling mid-cycle
   // -------------------------------------------------------------------------

   always @(negedge clk) begin
      fft_load_pkg::frame_beat_t exp_b;
      logic                      exp_last;
      if (!rst_n) begin
         if (valid_o || frame_done_o || rx_err_o) begin
            $display("Output strobe high while reset is asserted");
            misc_errs++;
         end
         done_exp  = 1'b0;
         seen_mask = '0;
      end else begin
         if (frame_done_o !== done_exp) begin
            $display("frame_done_o is %b where %b was expected", frame_done_o, done_exp);
            misc_errs++;
         end
         if (frame_done_o) begin
            frames_seen++;
         end
         done_exp = 1'b0;
         if (rx_err_o) begin
            rx_err_seen++;
         end
         if (valid_o) begin
            if (exp_q.size() == 0) begin
               $display("Beat on valid_o with no sample sent for it");
               misc_errs++;
            end else begin
               exp_b    = exp_q.pop_front();
               exp_last = last_q.pop_front();
               if (beat_o.sample.re !== exp_b.sample.re) begin
                  $display("[FAIL] beat_o.sample.re expected %h actual %h",
                           exp_b.sample.re, beat_o.sample.re);
                  val_errs++;
               end
               if (beat_o.sample.im !== exp_b.sample.im) begin
                  $display("[FAIL] beat_o.sample.im expected %h actual %h",
                           exp_b.sample.im, beat_o.sample.im);
                  val_errs++;
               end
               if (beat_o.addr !== exp_b.addr) begin
                  $display("[FAIL] beat_o.addr expected %h actual %h",
                           exp_b.addr, beat_o.addr);
                  val_errs++;
               end
               // Each slot once per frame
               if (seen_mask[beat_o.addr]) begin
                  $display("Address %0d used twice in one frame", beat_o.addr);
                  misc_errs++;
               end
               seen_mask[beat_o.addr] = 1'b1;
               if (exp_last) begin
                  if (seen_mask != '1) begin
                     $display("Frame ended without every address used");
                     misc_errs++;
                  end
                  seen_mask = '0;
               end
               done_exp = exp_last;
            end
         end
      end
   end

   // -------------------------------------------------------------------------
   // Run limit
   // -------------------------------------------------------------------------

   initial begin
      cycle_cnt = 0;
      while (cycle_cnt < TIMEOUT_CYCLES) begin
         @(posedge clk);
         cycle_cnt++;
      end
      $display("Run stopped after %0d cycles without reaching the end", cycle_cnt);
      misc_errs++;
      finish_run();
   end

   // -------------------------------------------------------------------------
   // Stimulus sequence
   // -------------------------------------------------------------------------

   initial begin
      rx_i        = 1'b1;
      rst_n       = 1'b0;
      model_cnt   = 0;
      val_errs    = 0;
      misc_errs   = 0;
      rx_err_exp  = 0;
      rx_err_seen = 0;
      frames_seen = 0;
      done_exp    = 1'b0;
      seen_mask   = '0;
      void'($urandom(SEED));
      repeat (10) @(posedge clk);
      rst_n <= 1'b1;
      repeat (4) @(posedge clk);

      // Frame 1 starts with corner values
      send_pair(8'h80, 8'h7F, 1'b0);
      send_pair(8'h00, 8'h80, 1'b0);
      send_pair(8'h7F, 8'h00, 1'b0);
      send_pair(8'hFF, 8'h01, 1'b1);
      send_random_pairs(12, -1);

      // Frames 2 and 3 back to back with one framing error
      send_random_pairs(2 * `FFT_POINTS, 21);
      drain_beats();

      // Reset in mid frame restarts the count at 0
      send_random_pairs(3, -1);
      drain_beats();
      pulse_reset();
      model_cnt = 0;
      send_random_pairs(2, -1);
      drain_beats();

      if (frames_seen != 3) begin
         $display("Saw %0d frame end pulses instead of 3", frames_seen);
         misc_errs++;
      end
      if (rx_err_seen != rx_err_exp) begin
         $display("Saw %0d framing errors instead of %0d", rx_err_seen, rx_err_exp);
         misc_errs++;
      end
      finish_run();
   end

endmodule

//--- sim/fft_load_sva.sv
// Protocol checks on the FFT load top level outputs, attached by bind to fft_load_top
`include "fft_load_defs.svh"

module fft_load_sva (
   input logic                      clk,
   input logic                      rst_n,
   input logic                      valid_i,
   input logic                      frame_done_i,
   input logic                      rx_err_i,
   input logic                      byte_valid_i,
   input fft_load_pkg::frame_beat_t beat_i
);

   timeunit 1ns;
   timeprecision 100ps;

   // -------------------------------------------------------------------------
   // Output strobes
   // -------------------------------------------------------------------------

   // Frame end comes after the last beat, never with it
   a_valid_done_excl: assert property (@(posedge clk) disable iff (!rst_n)
      !(valid_i && frame_done_i))
      else $error("valid_o and frame_done_o high in the same cycle");

   // Frame end only right behind a beat
   a_done_after_valid: assert property (@(posedge clk) disable iff (!rst_n)
      frame_done_i |-> $past(valid_i))
      else $error("frame_done_o without valid_o in the cycle before");

   // Dropped byte is never passed on
   a_err_no_byte: assert property (@(posedge clk) disable iff (!rst_n)
      !(rx_err_i && byte_valid_i))
      else $error("rx_err_o together with a byte passed on");

   // -------------------------------------------------------------------------
   // Known values
   // -------------------------------------------------------------------------

   a_strobes_known: assert property (@(posedge clk) disable iff (!rst_n)
      !$isunknown({valid_i, frame_done_i, rx_err_i}))
      else $error("Output strobe unknown after reset");

   // Payload only matters while valid
   a_beat_known: assert property (@(posedge clk) disable iff (!rst_n)
      valid_i |-> !$isunknown(beat_i))
      else $error("beat_o unknown while valid_o is high");

endmodule

bind fft_load_top fft_load_sva u_sva (
   .clk          (clk),
   .rst_n        (rst_n),
   .valid_i      (valid_o),
   .frame_done_i (frame_done_o),
   .rx_err_i     (rx_err_o),
   .byte_valid_i (byte_w.valid),
   .beat_i       (beat_o)
);

//--- logic/fft_load_top.sv
// FFT input stage top: serial bytes in, bit-reversed complex beats out
module fft_load_top (
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     rx_i,
   output fft_load_pkg::frame_beat_t beat_o,
   output logic                     valid_o,
   output logic                     frame_done_o,
   output logic                     rx_err_o
);

   // ------------------------------------------------------------------------
   // Stage to stage wires
   // ------------------------------------------------------------------------

   fft_load_pkg::rx_byte_t     byte_w;
   fft_load_pkg::cplx_sample_t sample_w;
   logic                       pair_valid_w;

   // Decode, serial line to bytes
   uart_rx u_uart_rx (
      .clk      (clk),
      .rst_n    (rst_n),
      .rx_i     (rx_i),
      .byte_o   (byte_w),
      .rx_err_o (rx_err_o)
   );

   // Execute, bytes to complex pairs
   sample_pack u_sample_pack (
      .clk          (clk),
      .rst_n        (rst_n),
      .byte_i       (byte_w),
      .sample_o     (sample_w),
      .pair_valid_o (pair_valid_w)
   );

   // Result, address and frame marking
   frame_loader u_frame_loader (
      .clk          (clk),
      .rst_n        (rst_n),
      .sample_i     (sample_w),
      .pair_valid_i (pair_valid_w),
      .beat_o       (beat_o),
      .valid_o      (valid_o),
      .frame_done_o (frame_done_o)
   );

endmodule

//--- logic/frame_loader.sv
// Result stage: counts samples, tags each with a bit-reversed address, flags frame end
`include "fft_load_defs.svh"

module frame_loader (
   input  logic                      clk,
   input  logic                      rst_n,
   input  fft_load_pkg::cplx_sample_t sample_i,
   input  logic                      pair_valid_i,
   output fft_load_pkg::frame_beat_t  beat_o,
   output logic                      valid_o,
   output logic                      frame_done_o
);

   // Final index of a frame
   localparam logic [`FFT_LOG2-1:0] LAST_IDX = `FFT_LOG2'(`FFT_POINTS - 1);

   fft_load_pkg::frame_beat_t beat_q;

   logic [`FFT_LOG2-1:0] count_q;
   logic [`FFT_LOG2-1:0] addr_rev;
   logic                 valid_q;
   logic                 last_beat_q;
   logic                 done_q;

   // ------------------------------------------------------------------------
   // Address reversal
   // ------------------------------------------------------------------------

   // Mirror the index bits, MSB to LSB
   function automatic logic [`FFT_LOG2-1:0] bit_rev(input logic [`FFT_LOG2-1:0] v);
      logic [`FFT_LOG2-1:0] r;
      for (int i = 0; i < `FFT_LOG2; i++) begin
         r[i] = v[`FFT_LOG2-1-i];
      end
      return r;
   endfunction

   assign addr_rev = bit_rev(count_q);

   // ------------------------------------------------------------------------
   // Sample counter and strobes
   // ------------------------------------------------------------------------

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         count_q     <= '0;
         valid_q     <= 1'b0;
         last_beat_q <= 1'b0;
         done_q      <= 1'b0;
      end else begin
         valid_q     <= pair_valid_i;
         // Remember that this beat closes the frame
         last_beat_q <= pair_valid_i && (count_q == LAST_IDX);
         done_q      <= last_beat_q;
         if (pair_valid_i) begin
            // Wrap starts the next frame
            if (count_q == LAST_IDX) begin
               count_q <= '0;
            end else begin
               count_q <= count_q + 1'b1;
            end
         end
      end
   end

   // Beat payload, qualified by valid_o
   always_ff @(posedge clk) begin
      if (pair_valid_i) begin
         beat_q.sample <= sample_i;
         beat_q.addr   <= addr_rev;
      end
   end

   assign beat_o       = beat_q;
   assign valid_o      = valid_q;
   assign frame_done_o = done_q;

endmodule

//--- logic/sample_pack.sv
// Execute stage: turns byte pairs into scaled complex samples for the frame loader
`include "fft_load_defs.svh"

module sample_pack (
   input  logic                      clk,
   input  logic                      rst_n,
   input  fft_load_pkg::rx_byte_t     byte_i,
   output fft_load_pkg::cplx_sample_t sample_o,
   output logic                      pair_valid_o
);

   fft_load_pkg::pack_state_e  state_q;
   fft_load_pkg::cplx_sample_t sample_q;

   logic [7:0] re_byte_q;
   logic       pair_vld_q;

   // ------------------------------------------------------------------------
   // Byte scaling
   // ------------------------------------------------------------------------

   // Signed byte times 256, sign bit copied up to SAMPLE_W
   function automatic logic [`SAMPLE_W-1:0] scale_byte(input logic [7:0] b);
      logic [`SAMPLE_W-1:0] w;
      w = {{(`SAMPLE_W - 16){b[7]}}, b, 8'h00};
      return w;
   endfunction

   // ------------------------------------------------------------------------
   // Pairing FSM
   // ------------------------------------------------------------------------

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state_q    <= fft_load_pkg::PACK_RE;
         pair_vld_q <= 1'b0;
      end else begin
         pair_vld_q <= 1'b0;
         if (byte_i.valid) begin
            case (state_q)
               fft_load_pkg::PACK_RE: begin
                  state_q <= fft_load_pkg::PACK_IM;
               end
               fft_load_pkg::PACK_IM: begin
                  // Pair complete, hand it on next cycle
                  state_q    <= fft_load_pkg::PACK_RE;
                  pair_vld_q <= 1'b1;
               end
               default: state_q <= fft_load_pkg::PACK_RE;
            endcase
         end
      end
   end

   // Real byte parked until its partner shows up
   always_ff @(posedge clk) begin
      if (byte_i.valid && state_q == fft_load_pkg::PACK_RE) begin
         re_byte_q <= byte_i.data;
      end
   end

   // Both halves scaled together on the imaginary byte
   always_ff @(posedge clk) begin
      if (byte_i.valid && state_q == fft_load_pkg::PACK_IM) begin
         sample_q.re <= scale_byte(re_byte_q);
         sample_q.im <= scale_byte(byte_i.data);
      end
   end

   assign sample_o     = sample_q;
   assign pair_valid_o = pair_vld_q;

endmodule

//--- logic/uart_rx.sv
// Decode stage: 8N1 serial receiver, samples mid-bit and passes checked bytes on
`include "fft_load_defs.svh"

module uart_rx (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  rx_i,
   output fft_load_pkg::rx_byte_t byte_o,
   output logic                  rx_err_o
);

   // Tick counter sized from the bit period
   localparam int TICK_W = $clog2(`UART_BIT_TICKS);
   localparam logic [TICK_W-1:0] BIT_LAST  = TICK_W'(`UART_BIT_TICKS - 1);
   localparam logic [TICK_W-1:0] HALF_LAST = TICK_W'(`UART_HALF_TICKS - 1);

   fft_load_pkg::rx_state_e state_q;

   logic              rx_s1_q;
   logic              rx_s2_q;
   logic              rx_prev_q;
   logic              fall_edge;
   logic [TICK_W-1:0] tick_q;
   logic [2:0]        bit_idx_q;
   logic [7:0]        shift_q;
   logic              byte_vld_q;
   logic              err_q;

   // ------------------------------------------------------------------------
   // Input synchronizer and start edge
   // ------------------------------------------------------------------------

   // Line idles high, so reset to 1
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rx_s1_q   <= 1'b1;
         rx_s2_q   <= 1'b1;
         rx_prev_q <= 1'b1;
      end else begin
         rx_s1_q   <= rx_i;
         rx_s2_q   <= rx_s1_q;
         rx_prev_q <= rx_s2_q;
      end
   end

   assign fall_edge = rx_prev_q & ~rx_s2_q;

   // ------------------------------------------------------------------------
   // Bit timing FSM
   // ------------------------------------------------------------------------

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state_q    <= fft_load_pkg::RX_IDLE;
         tick_q     <= '0;
         bit_idx_q  <= '0;
         byte_vld_q <= 1'b0;
         err_q      <= 1'b0;
      end else begin
         // Strobes last one cycle
         byte_vld_q <= 1'b0;
         err_q      <= 1'b0;
         tick_q     <= tick_q + 1'b1;
         case (state_q)
            fft_load_pkg::RX_IDLE: begin
               tick_q <= '0;
               if (fall_edge) begin
                  state_q <= fft_load_pkg::RX_START;
               end
            end
            fft_load_pkg::RX_START: begin
               // Mid start bit, reject glitches
               if (tick_q == HALF_LAST) begin
                  tick_q    <= '0;
                  bit_idx_q <= '0;
                  state_q   <= rx_s2_q ? fft_load_pkg::RX_IDLE : fft_load_pkg::RX_DATA;
               end
            end
            fft_load_pkg::RX_DATA: begin
               if (tick_q == BIT_LAST) begin
                  tick_q    <= '0;
                  bit_idx_q <= bit_idx_q + 1'b1;
                  if (bit_idx_q == 3'd7) begin
                     state_q <= fft_load_pkg::RX_STOP;
                  end
               end
            end
            fft_load_pkg::RX_STOP: begin
               // Stop bit decides pass or drop
               if (tick_q == BIT_LAST) begin
                  byte_vld_q <= rx_s2_q;
                  err_q      <= ~rx_s2_q;
                  state_q    <= fft_load_pkg::RX_IDLE;
               end
            end
            default: state_q <= fft_load_pkg::RX_IDLE;
         endcase
      end
   end

   // LSB arrives first, shift in from the top
   always_ff @(posedge clk) begin
      if (state_q == fft_load_pkg::RX_DATA && tick_q == BIT_LAST) begin
         shift_q <= {rx_s2_q, shift_q[7:1]};
      end
   end

   assign byte_o.data  = shift_q;
   assign byte_o.valid = byte_vld_q;
   assign rx_err_o     = err_q;

endmodule

//--- logic/fft_load_pkg.sv
// Shared types of the FFT load path: FSM states and the packed stream beats
`include "fft_load_defs.svh"

package fft_load_pkg;

   // ------------------------------------------------------------------------
   // FSM encodings
   // ------------------------------------------------------------------------

   // Serial receiver phases
   typedef enum logic [1:0] {
      RX_IDLE,
      RX_START,
      RX_DATA,
      RX_STOP
   } rx_state_e;

   // Which half of the complex pair is expected next
   typedef enum logic {
      PACK_RE,
      PACK_IM
   } pack_state_e;

   // ------------------------------------------------------------------------
   // Stream beats
   // ------------------------------------------------------------------------

   // One complex sample, two's complement words
   typedef struct packed {
      logic [`SAMPLE_W-1:0] re;
      logic [`SAMPLE_W-1:0] im;
   } cplx_sample_t;

   // Received byte plus single-cycle strobe
   typedef struct packed {
      logic [7:0] data;
      logic       valid;
   } rx_byte_t;

   // Output beat, sample with its bit-reversed slot
   typedef struct packed {
      cplx_sample_t         sample;
      logic [`FFT_LOG2-1:0] addr;
   } frame_beat_t;

endpackage

//--- include/fft_load_defs.svh
// Size and timing constants for the FFT load path, included by RTL and testbench
`ifndef FFT_LOAD_DEFS_SVH
`define FFT_LOAD_DEFS_SVH

// ---------------------------------------------------------------------------
// Frame geometry
// ---------------------------------------------------------------------------

// Complex samples per frame, power of two
`define FFT_POINTS 16

// Address width, log2 of FFT_POINTS
`define FFT_LOG2 4

// Width of one real or imaginary word
`define SAMPLE_W 32

// ---------------------------------------------------------------------------
// Serial line timing
// ---------------------------------------------------------------------------

// Clock cycles per UART bit
// Kept small so simulation stays short
`define UART_BIT_TICKS 16

// Offset from start edge to middle of the start bit
`define UART_HALF_TICKS 8

`endif
